/* rp_top.f */
src/rp_pkg.sv
src/sys_bus_if.sv
src/sys_bus_decoder.sv
src/analog_frontend.sv
src/housekeeping.sv
src/signal_router.sv
src/rp_top.sv
testbench/tb_clock.sv
testbench/tb_rp_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds with Verilator and runs; exit status follows the testbench verdict

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f rp_top.f --top-module tb_rp_top -o sim_tb_rp_top &&
./obj_dir/sim_tb_rp_top | tee /dev/stderr | grep -q "Test completed successfully" &&
{ echo "simulation: passed"; exit 0; } ||
{ echo "simulation: failed"; exit 1; }

/* src/analog_frontend.sv */
// uses the top ADC_W pin bits; ADC_W above SAMPLE_W drops lsbs, below pads them with zero
`timescale 1ns/1ns

module analog_frontend #(
  parameter int ADC_W = 14
) (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  input  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_b_i,
  input  logic                         digital_loop_i,
  input  rp_pkg::sample_t              dac_a_i,
  input  rp_pkg::sample_t              dac_b_i,
  output rp_pkg::sample_t              adc_a_o,
  output rp_pkg::sample_t              adc_b_o,
  output logic [rp_pkg::SAMPLE_W-1:0]  dac_dat_a_o,
  output logic [rp_pkg::SAMPLE_W-1:0]  dac_dat_b_o
);
  import rp_pkg::*;

  logic [ADC_W-1:0]    raw_a;     // pin registers
  logic [ADC_W-1:0]    raw_b;
  logic [SAMPLE_W-1:0] fit_a;     // resized to sample width
  logic [SAMPLE_W-1:0] fit_b;

  // negative slope <-> two's complement, same op both ways
  function automatic logic [SAMPLE_W-1:0] neg_slope(logic [SAMPLE_W-1:0] x);
    neg_slope = {x[SAMPLE_W-1], ~x[SAMPLE_W-2:0]};
  endfunction

  ////////////////////
  // adc side
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    raw_a <= adc_dat_a_i[ADC_PIN_W-1 -: ADC_W];  // msb aligned
    raw_b <= adc_dat_b_i[ADC_PIN_W-1 -: ADC_W];
  end

  if (ADC_W >= SAMPLE_W)
  begin : g_trim
    assign fit_a = raw_a[ADC_W-1 -: SAMPLE_W];
    assign fit_b = raw_b[ADC_W-1 -: SAMPLE_W];
  end
  else
  begin : g_pad
    assign fit_a = {raw_a, {(SAMPLE_W-ADC_W){1'b0}}};
    assign fit_b = {raw_b, {(SAMPLE_W-ADC_W){1'b0}}};
  end

  // loopback swaps in the dac samples
  assign adc_a_o = digital_loop_i ? dac_a_i : sample_t'(neg_slope(fit_a));
  assign adc_b_o = digital_loop_i ? dac_b_i : sample_t'(neg_slope(fit_b));

  ////////////////////
  // dac side
  ////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_a_o <= 14'h1FFF;                   // code of zero
      dac_dat_b_o <= 14'h1FFF;
    end
    else
    begin
      dac_dat_a_o <= neg_slope(dac_a_i);
      dac_dat_b_o <= neg_slope(dac_b_i);
    end
  end

endmodule

/* src/housekeeping.sv */
// region 0 registers; exp_p_i may be asynchronous and shows up in exp_in two cycles late
`timescale 1ns/1ns

module housekeeping (
  input  logic                     adc_clk,
  input  logic                     arst_n_i,
  sys_bus_if.slave                 bus,
  input  logic [rp_pkg::EXP_W-1:0] exp_p_i,
  output logic                     digital_loop_o,
  output logic [7:0]               led_o,
  output logic [rp_pkg::EXP_W-1:0] exp_p_o,
  output logic [rp_pkg::EXP_W-1:0] exp_dir_o
);
  import rp_pkg::*;

  logic [EXP_W-1:0]      exp_meta;   // first sync stage
  logic [EXP_W-1:0]      exp_sync;
  logic [REGION_LSB-1:0] ofs;
  logic [BUS_DW-1:0]     rd_val;
  logic                  hit;        // offset is mapped

  assign ofs = bus.addr[REGION_LSB-1:0];

  // two-flop synchronizer for the connector pins
  always_ff @(posedge adc_clk)
  begin
    exp_meta <= exp_p_i;
    exp_sync <= exp_meta;
  end

  ////////////////////
  // read decode
  ////////////////////

  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (ofs)
      HK_OFS_ID:      rd_val = HK_ID;
      HK_OFS_LOOP:    rd_val = BUS_DW'(digital_loop_o);
      HK_OFS_EXP_DIR: rd_val = BUS_DW'(exp_dir_o);
      HK_OFS_EXP_OUT: rd_val = BUS_DW'(exp_p_o);
      HK_OFS_EXP_IN:  rd_val = BUS_DW'(exp_sync);
      HK_OFS_LED:     rd_val = BUS_DW'(led_o);
      default:        hit    = 1'b0;
    endcase
  end

  ////////////////////
  // register writes
  ////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      exp_dir_o      <= '0;     // all pins inputs
      exp_p_o        <= '0;
    end
    else if (bus.wen)
    begin
      case (ofs)
        HK_OFS_LOOP:    digital_loop_o <= bus.wdata[0];
        HK_OFS_LED:     led_o          <= bus.wdata[7:0];
        HK_OFS_EXP_DIR: exp_dir_o      <= bus.wdata[EXP_W-1:0];
        HK_OFS_EXP_OUT: exp_p_o        <= bus.wdata[EXP_W-1:0];
        default:        ;            // id and exp_in ignore writes
      endcase
    end
  end

  // answer one cycle after the strobe
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      bus.ack   <= bus.wen | bus.ren;
      bus.err   <= (bus.wen | bus.ren) & ~hit;
      bus.rdata <= (bus.ren & hit) ? rd_val : '0;  // zero on errors
    end
  end

endmodule

/* src/rp_pkg.sv */
// single adc_clk domain; register offsets are byte addresses inside a 1 MB region
package rp_pkg;

  ////////////////////
  // system bus
  ////////////////////

  localparam int BUS_AW     = 32;
  localparam int BUS_DW     = 32;
  localparam int N_REGIONS  = 8;   // region field is addr[22:20]
  localparam int REGION_LSB = 20;
  localparam int REG_HK     = 0;   // housekeeping
  localparam int REG_ROUTER = 3;   // stands in for the dsp region

  ////////////////////
  // samples and pins
  ////////////////////

  localparam int SAMPLE_W  = 14;
  localparam int ADC_PIN_W = 16;   // low pins spare on a 14 bit converter
  localparam int EXP_W     = 8;

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // housekeeping map
  localparam logic [BUS_DW-1:0]     HK_ID          = 32'h5250_0001;
  localparam logic [REGION_LSB-1:0] HK_OFS_ID      = 'h00;  // read only
  localparam logic [REGION_LSB-1:0] HK_OFS_LOOP    = 'h0C;
  localparam logic [REGION_LSB-1:0] HK_OFS_EXP_DIR = 'h10;  // 1 = output
  localparam logic [REGION_LSB-1:0] HK_OFS_EXP_OUT = 'h14;
  localparam logic [REGION_LSB-1:0] HK_OFS_EXP_IN  = 'h18;  // read only
  localparam logic [REGION_LSB-1:0] HK_OFS_LED     = 'h30;

  // router map
  localparam logic [REGION_LSB-1:0] RT_OFS_SRC_A   = 'h00;
  localparam logic [REGION_LSB-1:0] RT_OFS_SRC_B   = 'h04;
  localparam logic [REGION_LSB-1:0] RT_OFS_CONST_A = 'h08;
  localparam logic [REGION_LSB-1:0] RT_OFS_CONST_B = 'h0C;

  // dac source per router channel
  typedef enum logic [1:0] {
    SRC_ADC_A = 2'd0,
    SRC_ADC_B = 2'd1,
    SRC_CONST = 2'd2,
    SRC_ZERO  = 2'd3
  } src_sel_t;

endpackage

/* src/rp_top.sv */
// adc_clk only; ADC_W is 14 or 16, and exp_p_o drives a pin only where exp_dir_o is set
`timescale 1ns/1ns

module rp_top #(
  parameter int ADC_W = 14
) (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  input  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_b_i,
  input  logic [rp_pkg::BUS_AW-1:0]    sys_addr_i,
  input  logic [rp_pkg::BUS_DW-1:0]    sys_wdata_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  input  logic [rp_pkg::EXP_W-1:0]     exp_p_i,
  output logic [rp_pkg::BUS_DW-1:0]    sys_rdata_o,
  output logic                         sys_err_o,
  output logic                         sys_ack_o,
  output logic [rp_pkg::SAMPLE_W-1:0]  dac_dat_a_o,
  output logic [rp_pkg::SAMPLE_W-1:0]  dac_dat_b_o,
  output logic [7:0]                   led_o,
  output logic [rp_pkg::EXP_W-1:0]     exp_p_o,
  output logic [rp_pkg::EXP_W-1:0]     exp_dir_o
);
  import rp_pkg::*;

  sample_t adc_a;          // converted, or looped back
  sample_t adc_b;
  sample_t dac_a;          // router out
  sample_t dac_b;
  logic    digital_loop;

  ////////////////////
  // bus
  ////////////////////

  sys_bus_if cpu_bus ();
  sys_bus_if region_bus [N_REGIONS] ();

  assign cpu_bus.addr  = sys_addr_i;
  assign cpu_bus.wdata = sys_wdata_i;
  assign cpu_bus.wen   = sys_wen_i;
  assign cpu_bus.ren   = sys_ren_i;
  assign sys_rdata_o   = cpu_bus.rdata;
  assign sys_err_o     = cpu_bus.err;
  assign sys_ack_o     = cpu_bus.ack;

  sys_bus_decoder u_dec (
    .adc_clk    (adc_clk),
    .cpu_bus    (cpu_bus),
    .region_bus (region_bus)
  );

  ////////////////////
  // analog path
  ////////////////////

  analog_frontend #(
    .ADC_W (ADC_W)
  ) u_afe (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  housekeeping u_hk (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .bus            (region_bus[REG_HK]),
    .exp_p_i        (exp_p_i),
    .digital_loop_o (digital_loop),
    .led_o          (led_o),
    .exp_p_o        (exp_p_o),
    .exp_dir_o      (exp_dir_o)
  );

  signal_router u_rt (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .bus      (region_bus[REG_ROUTER]),
    .adc_a_i  (adc_a),
    .adc_b_i  (adc_b),
    .dac_a_o  (dac_a),
    .dac_b_o  (dac_b)
  );

endmodule

/* src/signal_router.sv */
// region 3 stand-in for the dsp; output is registered, so a source change lands one cycle on
`timescale 1ns/1ns

module signal_router (
  input  logic            adc_clk,
  input  logic            arst_n_i,
  sys_bus_if.slave        bus,
  input  rp_pkg::sample_t adc_a_i,
  input  rp_pkg::sample_t adc_b_i,
  output rp_pkg::sample_t dac_a_o,
  output rp_pkg::sample_t dac_b_o
);
  import rp_pkg::*;

  src_sel_t              src_a_q;
  src_sel_t              src_b_q;
  sample_t               const_a_q;
  sample_t               const_b_q;
  logic [REGION_LSB-1:0] ofs;
  logic [BUS_DW-1:0]     rd_val;
  logic                  hit;

  assign ofs = bus.addr[REGION_LSB-1:0];

  // one channel's source mux
  function automatic sample_t pick(src_sel_t sel, sample_t k, sample_t a, sample_t b);
    case (sel)
      SRC_ADC_A: pick = a;
      SRC_ADC_B: pick = b;
      SRC_CONST: pick = k;
      default:   pick = '0;   // SRC_ZERO
    endcase
  endfunction

  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (ofs)
      RT_OFS_SRC_A:   rd_val = BUS_DW'(src_a_q);
      RT_OFS_SRC_B:   rd_val = BUS_DW'(src_b_q);
      RT_OFS_CONST_A: rd_val = {{(BUS_DW-SAMPLE_W){1'b0}}, const_a_q};  // no sign ext
      RT_OFS_CONST_B: rd_val = {{(BUS_DW-SAMPLE_W){1'b0}}, const_b_q};
      default:        hit    = 1'b0;
    endcase
  end

  ////////////////////
  // config and datapath
  ////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      src_a_q   <= SRC_ZERO;
      src_b_q   <= SRC_ZERO;
      const_a_q <= '0;
      const_b_q <= '0;
      dac_a_o   <= '0;
      dac_b_o   <= '0;
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      if (bus.wen)
      begin
        case (ofs)
          RT_OFS_SRC_A:   src_a_q   <= src_sel_t'(bus.wdata[1:0]);
          RT_OFS_SRC_B:   src_b_q   <= src_sel_t'(bus.wdata[1:0]);
          RT_OFS_CONST_A: const_a_q <= sample_t'(bus.wdata[SAMPLE_W-1:0]);
          RT_OFS_CONST_B: const_b_q <= sample_t'(bus.wdata[SAMPLE_W-1:0]);
          default:        ;
        endcase
      end
      dac_a_o   <= pick(src_a_q, const_a_q, adc_a_i, adc_b_i);
      dac_b_o   <= pick(src_b_q, const_b_q, adc_a_i, adc_b_i);
      bus.ack   <= bus.wen | bus.ren;
      bus.err   <= (bus.wen | bus.ren) & ~hit;
      bus.rdata <= (bus.ren & hit) ? rd_val : '0;
    end
  end

  // one ack per access needs strobes that end after one cycle
  assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (bus.wen || bus.ren) |=> !(bus.wen || bus.ren));

endmodule

/* src/sys_bus_decoder.sv */
// purely combinational; unused regions ack at once, so their strobes finish in the same cycle
`timescale 1ns/1ns

module sys_bus_decoder (
  input  logic      adc_clk,                          // only for the strobe check
  sys_bus_if.slave  cpu_bus,
  sys_bus_if.master region_bus [rp_pkg::N_REGIONS]
);
  import rp_pkg::*;

  localparam int RW = $clog2(N_REGIONS);

  // regions with a real slave behind them
  localparam logic [N_REGIONS-1:0] USED = (N_REGIONS'(1) << REG_HK)
                                        | (N_REGIONS'(1) << REG_ROUTER);

  logic [RW-1:0]        idx;
  logic [N_REGIONS-1:0] sel;                          // one-hot
  logic [BUS_DW-1:0]    rd_arr [N_REGIONS];
  logic [N_REGIONS-1:0] ack_arr;
  logic [N_REGIONS-1:0] err_arr;

  assign idx = cpu_bus.addr[REGION_LSB +: RW];
  assign sel = N_REGIONS'(1) << idx;

  ////////////////////
  // fan-out
  ////////////////////

  for (genvar i = 0; i < N_REGIONS; i++)
  begin : g_region
    assign region_bus[i].addr  = cpu_bus.addr;
    assign region_bus[i].wdata = cpu_bus.wdata;
    assign region_bus[i].wen   = cpu_bus.wen & sel[i];  // strobe only the selected one
    assign region_bus[i].ren   = cpu_bus.ren & sel[i];

    if (USED[i])
    begin : g_used
      assign rd_arr[i]  = region_bus[i].rdata;
      assign ack_arr[i] = region_bus[i].ack;
      assign err_arr[i] = region_bus[i].err;
    end
    else
    begin : g_unused
      assign rd_arr[i]  = '0;    // empty slot reads zero
      assign ack_arr[i] = 1'b1;  // always ready
      assign err_arr[i] = 1'b0;
    end
  end

  ////////////////////
  // return path
  ////////////////////

  assign cpu_bus.rdata = rd_arr[idx];
  assign cpu_bus.ack   = |(sel & ack_arr);
  assign cpu_bus.err   = |(sel & err_arr);

  // requester must never read and write at once
  assert property (@(posedge adc_clk) !(cpu_bus.wen && cpu_bus.ren));

endmodule

/* src/sys_bus_if.sv */
// plain strobe/ack bus: one-cycle strobes, whole-word writes, no back-pressure
`timescale 1ns/1ns

interface sys_bus_if;
  import rp_pkg::*;

  logic [BUS_AW-1:0] addr;   // full byte address, region bits included
  logic [BUS_DW-1:0] wdata;
  logic              wen;    // write strobe, one cycle
  logic              ren;    // read strobe, one cycle
  logic [BUS_DW-1:0] rdata;  // valid with ack on reads
  logic              err;    // only together with ack
  logic              ack;

  // requester side
  modport master (
    output addr,
    output wdata,
    output wen,
    output ren,
    input  rdata,
    input  err,
    input  ack
  );

  // responder side
  modport slave (
    input  addr,
    input  wdata,
    input  wen,
    input  ren,
    output rdata,
    output err,
    output ack
  );

endinterface

/* testbench/tb_clock.sv */
// free running 100 ns clock; reset is held over the first 16 rising edges, then released
`timescale 1ns/1ns

module tb_clock (
  output logic adc_clk,
  output logic arst_n_o
);

  initial
  begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;   // 100 ns period
  end

  initial
  begin
    arst_n_o = 1'b0;
    repeat (16) @(posedge adc_clk);
    @(negedge adc_clk);               // release away from the active edge
    arst_n_o = 1'b1;
  end

endmodule

/* testbench/tb_rp_top.sv */
// expects the DUT built with ADC_W = 14; one bus access at a time, inputs change on falling edges
`timescale 1ns/1ns

module tb_rp_top;
  import rp_pkg::*;

  localparam int N_HK      = 8;     // random housekeeping rounds
  localparam int N_SAMPLES = 12;    // samples per source combination
  localparam int MAX_WAIT  = 8;     // cycles allowed for a late ack
  localparam int N_BUS_OPS = N_HK * 10 + 16 * 6 + 30;
  localparam int N_SMP_CYC = 16 * (N_SAMPLES + 3) + N_HK * 4 + 10;
  localparam int WDOG_CYC  = (N_BUS_OPS + N_SMP_CYC) * 20 + 16 + 200;

  logic                 adc_clk;
  logic                 arst_n;
  logic [ADC_PIN_W-1:0] adc_a_pin;
  logic [ADC_PIN_W-1:0] adc_b_pin;
  logic [BUS_AW-1:0]    sys_addr;
  logic [BUS_DW-1:0]    sys_wdata;
  logic                 sys_wen;
  logic                 sys_ren;
  logic [EXP_W-1:0]     exp_p;
  logic [BUS_DW-1:0]    sys_rdata;
  logic                 sys_err;
  logic                 sys_ack;
  logic [SAMPLE_W-1:0]  dac_dat_a;
  logic [SAMPLE_W-1:0]  dac_dat_b;
  logic [7:0]           led;
  logic [EXP_W-1:0]     exp_out;
  logic [EXP_W-1:0]     exp_dir;

  integer seed;
  int     errors;
  int     err_mark;       // error count at start of the current test
  int     tests_ok;
  int     tests_bad;
  logic [BUS_DW-1:0] got_rd;        // last bus answer
  logic              got_err;
  logic              got_ack;
  logic              early_ack;     // ack seen inside the strobe cycle

  // register model
  logic [7:0]          m_led;
  logic [EXP_W-1:0]    m_dir;
  logic [EXP_W-1:0]    m_out;
  logic [1:0]          m_src_a;
  logic [1:0]          m_src_b;
  logic [SAMPLE_W-1:0] m_const_a;
  logic [SAMPLE_W-1:0] m_const_b;

  tb_clock u_clk (.adc_clk(adc_clk), .arst_n_o(arst_n));

  rp_top #(.ADC_W(14)) dut0 (
    .adc_clk(adc_clk), .arst_n_i(arst_n),
    .adc_dat_a_i(adc_a_pin), .adc_dat_b_i(adc_b_pin),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata),
    .sys_wen_i(sys_wen), .sys_ren_i(sys_ren), .exp_p_i(exp_p),
    .sys_rdata_o(sys_rdata), .sys_err_o(sys_err), .sys_ack_o(sys_ack),
    .dac_dat_a_o(dac_dat_a), .dac_dat_b_o(dac_dat_b),
    .led_o(led), .exp_p_o(exp_out), .exp_dir_o(exp_dir)
  );

  ////////////////////
  // model helpers
  ////////////////////

  // sign bit kept, rest inverted; the mapping is its own inverse
  function automatic logic [SAMPLE_W-1:0] flip_code(input logic [SAMPLE_W-1:0] v);
    flip_code = v ^ {1'b0, {(SAMPLE_W-1){1'b1}}};
  endfunction

  // dac pin code for one channel, from the raw adc codes
  function automatic logic [SAMPLE_W-1:0] route_code(input logic [1:0] src,
      input logic [SAMPLE_W-1:0] k, input logic [SAMPLE_W-1:0] ra, input logic [SAMPLE_W-1:0] rb);
    logic [SAMPLE_W-1:0] s;
    if (src == SRC_ADC_A)
      s = flip_code(ra);
    else if (src == SRC_ADC_B)
      s = flip_code(rb);
    else if (src == SRC_CONST)
      s = k;
    else
      s = '0;
    route_code = flip_code(s);
  endfunction

  function automatic logic [BUS_AW-1:0] reg_addr(input int region,
      input logic [REGION_LSB-1:0] ofs);
    reg_addr = (BUS_AW'(region) << REGION_LSB) | BUS_AW'(ofs);
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
      input logic [31:0] act_v);
    $display("FAIL %0t ns %s expected %h got %h", $time, sig, exp_v, act_v);
    errors++;
  endtask

  task automatic close_test(input string name);
    if (errors == err_mark)
    begin
      tests_ok++;
      $display("%0t ns  %s ... passed", $time, name);
    end
    else
    begin
      tests_bad++;
      $display("%0t ns  %s ... %0d errors", $time, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  ////////////////////
  // bus access
  ////////////////////

  // one-cycle strobe, answer sampled on the next falling edge
  task automatic bus_op(input logic wr, input logic [BUS_AW-1:0] addr,
      input logic [BUS_DW-1:0] wdata);
    int n;
    @(negedge adc_clk);
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = wr;
    sys_ren   = ~wr;
    #25;                             // mid low phase
    early_ack = sys_ack;
    @(negedge adc_clk);
    n       = 0;
    got_ack = sys_ack;
    got_err = sys_err;
    got_rd  = sys_rdata;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    while (!got_ack && n < MAX_WAIT)
    begin
      @(negedge adc_clk);
      n++;
      got_ack = sys_ack;
      got_err = sys_err;
      got_rd  = sys_rdata;
    end
    if (!got_ack)
    begin
      $display("no ack for the access to address %h within %0d cycles", addr, MAX_WAIT);
      errors++;
    end
  endtask

  task automatic reg_write(input int region, input logic [REGION_LSB-1:0] ofs,
      input logic [BUS_DW-1:0] d);
    bus_op(1'b1, reg_addr(region, ofs), d);
    if (got_err !== 1'b0)
      report_mismatch("sys_err_o", 0, got_err);
  endtask

  task automatic read_expect(input int region, input logic [REGION_LSB-1:0] ofs,
      input logic [BUS_DW-1:0] exp_v, input string name);
    bus_op(1'b0, reg_addr(region, ofs), '0);
    if (got_err !== 1'b0)
      report_mismatch("sys_err_o", 0, got_err);
    if (got_rd !== exp_v)
      report_mismatch(name, exp_v, got_rd);
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic check_reset;
    @(negedge adc_clk);
    if (led !== 8'h00) report_mismatch("led_o", 0, led);
    if (exp_dir !== '0) report_mismatch("exp_dir_o", 0, exp_dir);
    if (sys_ack !== 1'b0) report_mismatch("sys_ack_o", 0, sys_ack);
    if (sys_err !== 1'b0) report_mismatch("sys_err_o", 0, sys_err);
    if (dac_dat_a !== 14'h1FFF) report_mismatch("dac_dat_a_o", 14'h1FFF, dac_dat_a);
    if (dac_dat_b !== 14'h1FFF) report_mismatch("dac_dat_b_o", 14'h1FFF, dac_dat_b);
    read_expect(REG_HK, HK_OFS_LOOP, 0, "loop reg");
    read_expect(REG_ROUTER, RT_OFS_SRC_A, 32'(SRC_ZERO), "src_a reg");
    read_expect(REG_ROUTER, RT_OFS_SRC_B, 32'(SRC_ZERO), "src_b reg");
  endtask

  task automatic exercise_housekeeping;
    logic [BUS_DW-1:0] w;
    logic [EXP_W-1:0]  pins;
    for (int r = 0; r < N_HK; r++)
    begin
      w = $random(seed);
      reg_write(REG_HK, HK_OFS_LED, w);
      m_led = w[7:0];
      if (led !== m_led) report_mismatch("led_o", m_led, led);
      w = $random(seed);
      reg_write(REG_HK, HK_OFS_EXP_DIR, w);
      m_dir = w[EXP_W-1:0];
      if (exp_dir !== m_dir) report_mismatch("exp_dir_o", m_dir, exp_dir);
      w = $random(seed);
      reg_write(REG_HK, HK_OFS_EXP_OUT, w);
      m_out = w[EXP_W-1:0];
      if (exp_out !== m_out) report_mismatch("exp_p_o", m_out, exp_out);
      w = $random(seed);
      reg_write(REG_HK, HK_OFS_LOOP, w);           // only bit 0 sticks
      read_expect(REG_HK, HK_OFS_LOOP, 32'(w[0]), "loop reg");
      read_expect(REG_HK, HK_OFS_LED, 32'(m_led), "led reg");
      read_expect(REG_HK, HK_OFS_EXP_DIR, 32'(m_dir), "exp_dir reg");
      read_expect(REG_HK, HK_OFS_EXP_OUT, 32'(m_out), "exp_out reg");
      reg_write(REG_HK, HK_OFS_ID, $random(seed)); // read only
      read_expect(REG_HK, HK_OFS_ID, HK_ID, "id reg");
      @(negedge adc_clk);
      pins  = 8'($random(seed));
      exp_p = pins;
      repeat (3) @(negedge adc_clk);               // through the synchronizer
      read_expect(REG_HK, HK_OFS_EXP_IN, 32'(pins), "exp_in reg");
    end
    reg_write(REG_HK, HK_OFS_LOOP, 0);
  endtask

  task automatic expect_err(input logic wr, input int region, input logic [REGION_LSB-1:0] ofs);
    bus_op(wr, reg_addr(region, ofs), $random(seed));
    if (early_ack !== 1'b0) report_mismatch("sys_ack_o early", 0, early_ack);
    if (got_err !== 1'b1) report_mismatch("sys_err_o", 1, got_err);
    if (got_rd !== '0) report_mismatch("sys_rdata_o", 0, got_rd);
  endtask

  task automatic probe_bus_errors;
    logic [REGION_LSB-1:0] ofs;
    expect_err(1'b0, REG_HK, 'h04);
    expect_err(1'b1, REG_HK, 'h40);
    expect_err(1'b0, REG_ROUTER, 'h10);
    expect_err(1'b1, REG_ROUTER, 'h20);
    for (int r = 0; r < N_REGIONS; r++)
    begin
      if (r != REG_HK && r != REG_ROUTER)
      begin
        ofs = 20'($random(seed)) & 20'hFFFFC;
        for (int wr = 0; wr < 2; wr++)
        begin
          bus_op(wr[0], reg_addr(r, ofs), $random(seed));
          if (early_ack !== 1'b1) report_mismatch("sys_ack_o early", 1, early_ack);
          if (got_err !== 1'b0) report_mismatch("sys_err_o", 0, got_err);
          if (got_rd !== '0) report_mismatch("sys_rdata_o", 0, got_rd);
        end
      end
    end
  endtask

  task automatic sweep_routing;
    logic [SAMPLE_W-1:0] exp_a_q [$];
    logic [SAMPLE_W-1:0] exp_b_q [$];
    logic [SAMPLE_W-1:0] ea;
    logic [SAMPLE_W-1:0] eb;
    logic [BUS_DW-1:0]   w;
    for (int sa = 0; sa < 4; sa++)
    begin
      for (int sb = 0; sb < 4; sb++)
      begin
        w = $random(seed);
        reg_write(REG_ROUTER, RT_OFS_CONST_A, w);
        m_const_a = w[SAMPLE_W-1:0];
        w = $random(seed);
        reg_write(REG_ROUTER, RT_OFS_CONST_B, w);
        m_const_b = w[SAMPLE_W-1:0];
        w = $random(seed);
        reg_write(REG_ROUTER, RT_OFS_SRC_A, {w[31:2], 2'(sa)});  // upper bits dropped
        m_src_a = 2'(sa);
        reg_write(REG_ROUTER, RT_OFS_SRC_B, {w[31:2], 2'(sb)});
        m_src_b = 2'(sb);
        read_expect(REG_ROUTER, RT_OFS_SRC_A, 32'(m_src_a), "src_a reg");
        read_expect(REG_ROUTER, RT_OFS_CONST_A, 32'(m_const_a), "const_a reg");
        for (int i = 0; i < N_SAMPLES + 3; i++)
        begin
          @(negedge adc_clk);
          if (i >= 3)                              // adc reg, router reg, dac reg
          begin
            ea = exp_a_q.pop_front();
            eb = exp_b_q.pop_front();
            if (dac_dat_a !== ea) report_mismatch("dac_dat_a_o", ea, dac_dat_a);
            if (dac_dat_b !== eb) report_mismatch("dac_dat_b_o", eb, dac_dat_b);
          end
          if (i < N_SAMPLES)
          begin
            adc_a_pin = 16'($random(seed));
            adc_b_pin = 16'($random(seed));
            exp_a_q.push_back(route_code(m_src_a, m_const_a, adc_a_pin[15 -: SAMPLE_W],
                                         adc_b_pin[15 -: SAMPLE_W]));
            exp_b_q.push_back(route_code(m_src_b, m_const_b, adc_a_pin[15 -: SAMPLE_W],
                                         adc_b_pin[15 -: SAMPLE_W]));
          end
        end
      end
    end
  endtask

  task automatic verify_loopback;
    logic [SAMPLE_W-1:0] k;
    k = 14'($random(seed));
    reg_write(REG_HK, HK_OFS_LOOP, 1);
    reg_write(REG_ROUTER, RT_OFS_CONST_A, 32'(k));
    reg_write(REG_ROUTER, RT_OFS_SRC_A, 32'(SRC_CONST));
    reg_write(REG_ROUTER, RT_OFS_SRC_B, 32'(SRC_ADC_A));  // b follows a's own output
    repeat (6)
    begin
      @(negedge adc_clk);
      adc_a_pin = 16'($random(seed));   // must be ignored
      adc_b_pin = 16'($random(seed));
    end
    @(negedge adc_clk);
    if (dac_dat_a !== flip_code(k)) report_mismatch("dac_dat_a_o", flip_code(k), dac_dat_a);
    if (dac_dat_b !== flip_code(k)) report_mismatch("dac_dat_b_o", flip_code(k), dac_dat_b);
    reg_write(REG_HK, HK_OFS_LOOP, 0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    seed      = 32'h5db9_5b9b;
    errors    = 0;
    err_mark  = 0;
    tests_ok  = 0;
    tests_bad = 0;
    adc_a_pin = '0;
    adc_b_pin = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    exp_p     = '0;
    wait (arst_n === 1'b1);
    check_reset;
    close_test("reset values");
    exercise_housekeeping;
    close_test("housekeeping registers");
    probe_bus_errors;
    close_test("bus errors");
    sweep_routing;
    close_test("routing");
    verify_loopback;
    close_test("digital loop");
    $display("summary: %0d tests passed, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog sized from the bus operations and sample cycles above
  initial
  begin
    repeat (WDOG_CYC) @(posedge adc_clk);
    $display("watchdog: run did not finish within %0d cycles", WDOG_CYC);
    $display("Test failed");
    $finish;
  end

endmodule
